/* dbg_i2c.sv */
// I2C debug interface top, line filter feeding link layer and command layer
`timescale 1ns/1ps

module dbg_i2c import dbg_i2c_pkg::*; #(
  parameter logic [6:0] I2C_ADDR = 7'h50  // Device address on the bus
) (
  input  logic                  dbg_clk,
  input  logic                  dbg_rst,
  input  logic                  dbg_i2c_scl,
  input  logic                  dbg_i2c_sda_in,
  output logic                  dbg_i2c_sda_out,  // 0 pulls SDA low
  output logic [DBG_ADDR_W-1:0] dbg_addr,
  output logic [DBG_DATA_W-1:0] dbg_din,
  output logic                  dbg_wr,
  output logic                  dbg_rd,
  input  logic [DBG_DATA_W-1:0] dbg_dout
);

  // Filtered bus
  logic scl;
  logic sda;
  logic scl_fe;
  logic scl_re;
  logic sda_fe;
  logic sda_re;
  logic scl_sample;

  // Link to command layer
  dbg_cmd_u              rx_byte;
  logic                  rx_byte_done;
  logic                  tx_byte_done;
  logic [I2C_BYTE_W-1:0] tx_byte;

  dbg_i2c_line_filter i_line_filter (
    .dbg_clk    (dbg_clk),
    .dbg_rst    (dbg_rst),
    .scl_pin    (dbg_i2c_scl),
    .sda_pin    (dbg_i2c_sda_in),
    .scl        (scl),
    .sda        (sda),
    .scl_fe     (scl_fe),
    .scl_re     (scl_re),
    .sda_fe     (sda_fe),
    .sda_re     (sda_re),
    .scl_sample (scl_sample)
  );

  dbg_i2c_link #(
    .I2C_ADDR (I2C_ADDR)
  ) i_link (
    .dbg_clk      (dbg_clk),
    .dbg_rst      (dbg_rst),
    .scl          (scl),
    .sda          (sda),
    .scl_fe       (scl_fe),
    .scl_re       (scl_re),
    .sda_fe       (sda_fe),
    .sda_re       (sda_re),
    .scl_sample   (scl_sample),
    .tx_byte      (tx_byte),
    .rx_byte      (rx_byte),
    .rx_byte_done (rx_byte_done),
    .tx_byte_done (tx_byte_done),
    .sda_out      (dbg_i2c_sda_out)
  );

  dbg_i2c_cmd i_cmd (
    .dbg_clk      (dbg_clk),
    .dbg_rst      (dbg_rst),
    .rx_byte      (rx_byte),
    .rx_byte_done (rx_byte_done),
    .tx_byte_done (tx_byte_done),
    .dbg_dout     (dbg_dout),
    .tx_byte      (tx_byte),
    .dbg_addr     (dbg_addr),
    .dbg_din      (dbg_din),
    .dbg_wr       (dbg_wr),
    .dbg_rd       (dbg_rd)
  );

endmodule

/* dbg_i2c_cmd.sv */
// Debug command layer turning received bytes into register reads and writes
`timescale 1ns/1ps

module dbg_i2c_cmd import dbg_i2c_pkg::*; (
  input  logic                  dbg_clk,
  input  logic                  dbg_rst,
  input  dbg_cmd_u              rx_byte,
  input  logic                  rx_byte_done,
  input  logic                  tx_byte_done,
  input  logic [DBG_DATA_W-1:0] dbg_dout,   // Register read data
  output logic [I2C_BYTE_W-1:0] tx_byte,
  output logic [DBG_ADDR_W-1:0] dbg_addr,
  output logic [DBG_DATA_W-1:0] dbg_din,
  output logic                  dbg_wr,     // One-cycle write strobe
  output logic                  dbg_rd      // One-cycle read strobe
);

  dbg_state_e            state;
  dbg_state_e            state_nxt;
  logic                  dbg_bw;       // 1 = 8-bit access
  logic                  cmd_valid;
  logic                  rx_lo_valid;
  logic                  rx_hi_valid;
  logic [I2C_BYTE_W-1:0] din_lo;
  logic [I2C_BYTE_W-1:0] din_hi;

  // ==============================
  // Command FSM
  // ==============================

  always_comb begin
    state_nxt = state;
    case (state)
      RX_CMD: begin
        if (rx_byte_done) begin
          state_nxt = rx_byte.cmd.wr ? RX_BYTE_LO : TX_BYTE_LO;
        end
      end
      RX_BYTE_LO: begin
        if (rx_byte_done) begin
          state_nxt = dbg_bw ? RX_CMD : RX_BYTE_HI;  // High byte skipped in 8-bit mode
        end
      end
      RX_BYTE_HI: begin
        if (rx_byte_done) begin
          state_nxt = RX_CMD;
        end
      end
      TX_BYTE_LO: begin
        if (tx_byte_done) begin
          state_nxt = dbg_bw ? RX_CMD : TX_BYTE_HI;
        end
      end
      TX_BYTE_HI: begin
        if (tx_byte_done) begin
          state_nxt = RX_CMD;
        end
      end
      default: state_nxt = RX_CMD;
    endcase
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state <= RX_CMD;
    end else begin
      state <= state_nxt;
    end
  end

  assign cmd_valid   = (state == RX_CMD) & rx_byte_done;
  assign rx_lo_valid = (state == RX_BYTE_LO) & rx_byte_done;
  assign rx_hi_valid = (state == RX_BYTE_HI) & rx_byte_done;

  // ==============================
  // Register access
  // ==============================

  // Address and width held from the command byte
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_bw   <= 1'b0;
      dbg_addr <= '0;
    end else if (cmd_valid) begin
      dbg_bw   <= rx_byte.cmd.bw;
      dbg_addr <= rx_byte.cmd.addr;
    end
  end

  // Write word, low byte first
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      din_lo <= '0;
      din_hi <= '0;
    end else if (rx_lo_valid) begin
      din_lo <= rx_byte.data;
      din_hi <= '0;                 // Clean high half for byte writes
    end else if (rx_hi_valid) begin
      din_hi <= rx_byte.data;
    end
  end

  assign dbg_din = {din_hi, din_lo};

  // Strobes, one cycle after the completing byte
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_wr <= 1'b0;
      dbg_rd <= 1'b0;
    end else begin
      dbg_wr <= dbg_bw ? rx_lo_valid : rx_hi_valid;
      dbg_rd <= cmd_valid & ~rx_byte.cmd.wr;  // Fetch ahead of the read transfer
    end
  end

  // Half of the read word for the link layer
  assign tx_byte = (state == TX_BYTE_HI) ? dbg_dout[DBG_DATA_W-1:I2C_BYTE_W]
                                         : dbg_dout[I2C_BYTE_W-1:0];

endmodule

/* dbg_i2c_line_filter.sv */
// SCL/SDA input conditioning with synchronizers, glitch filter and edge strobes
`timescale 1ns/1ps

module dbg_i2c_line_filter (
  input  logic dbg_clk,
  input  logic dbg_rst,
  input  logic scl_pin,     // Raw SCL from the bus
  input  logic sda_pin,     // Raw SDA from the bus
  output logic scl,         // Filtered SCL level
  output logic sda,         // Filtered SDA level
  output logic scl_fe,
  output logic scl_re,
  output logic sda_fe,
  output logic sda_re,
  output logic scl_sample   // Mid high phase strobe for SDA sampling
);

  // Both lines handled side by side, bit 0 = SCL, bit 1 = SDA
  logic [1:0] pin;
  logic [1:0] sync_q1;
  logic [1:0] sync_q2;
  logic [1:0] buf_q1;
  logic [1:0] buf_q2;
  logic [1:0] filt;
  logic [1:0] filt_dly;
  logic [1:0] fall;
  logic [1:0] rise;
  logic [1:0] scl_re_dly;

  assign pin = {sda_pin, scl_pin};

  // ==============================
  // Synchronizer and filter
  // ==============================

  // Two-flop synchronizer, idle bus is high
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      sync_q1 <= 2'b11;
      sync_q2 <= 2'b11;
    end else begin
      sync_q1 <= pin;
      sync_q2 <= sync_q1;
    end
  end

  // History for the majority window
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      buf_q1 <= 2'b11;
      buf_q2 <= 2'b11;
    end else begin
      buf_q1 <= sync_q2;
      buf_q2 <= buf_q1;
    end
  end

  // 2 out of 3 vote drops single-cycle glitches
  assign filt = (sync_q2 & buf_q1) | (sync_q2 & buf_q2) | (buf_q1 & buf_q2);

  // ==============================
  // Edges and sample strobe
  // ==============================

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      filt_dly   <= 2'b11;
      scl_re_dly <= 2'b00;
    end else begin
      filt_dly   <= filt;
      scl_re_dly <= {scl_re_dly[0], scl_re};  // SCL rise pipeline
    end
  end

  assign fall = filt_dly & ~filt;
  assign rise = ~filt_dly & filt;

  assign scl        = filt[0];
  assign sda        = filt[1];
  assign scl_fe     = fall[0];
  assign scl_re     = rise[0];
  assign sda_fe     = fall[1];
  assign sda_re     = rise[1];
  assign scl_sample = scl_re_dly[1];  // Two cycles after the rise

endmodule

/* dbg_i2c_link.sv */
// I2C slave byte protocol with start/stop detection, shifter and SDA driver
`timescale 1ns/1ps

module dbg_i2c_link import dbg_i2c_pkg::*; #(
  parameter logic [6:0] I2C_ADDR = 7'h50  // 7-bit device address
) (
  input  logic                  dbg_clk,
  input  logic                  dbg_rst,
  input  logic                  scl,
  input  logic                  sda,
  input  logic                  scl_fe,
  input  logic                  scl_re,
  input  logic                  sda_fe,
  input  logic                  sda_re,
  input  logic                  scl_sample,
  input  logic [I2C_BYTE_W-1:0] tx_byte,       // Next byte for the master
  output dbg_cmd_u              rx_byte,
  output logic                  rx_byte_done,  // Data byte in, not address
  output logic                  tx_byte_done,
  output logic                  sda_out        // Open drain, 0 pulls low
);

  // ==============================
  // Start, stop and activity
  // ==============================

  logic       start_det;
  logic       stop_det;
  logic       addr_miss;
  logic       active_q;
  logic       active;
  logic       i2c_init;
  i2c_state_e state;
  i2c_state_e state_nxt;
  logic [8:0] shift_q;      // Byte plus marker bit
  logic [8:0] shift_nxt;
  logic       shift_rx_en;
  logic       shift_tx_en;
  logic       shift_tx_en_pre;
  logic       shift_rx_done;
  logic       shift_tx_done;
  logic       rx_init;
  logic       tx_init;
  logic       rx_shift;
  logic       tx_shift;

  assign start_det = sda_fe & scl;  // SDA falls with SCL high
  assign stop_det  = sda_re & scl;  // SDA rises with SCL high

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      active_q <= 1'b0;
    end else if (start_det) begin
      active_q <= 1'b1;
    end else if (stop_det || addr_miss) begin
      active_q <= 1'b0;  // Bus released or not for us
    end
  end

  assign active   = active_q & ~stop_det;
  assign i2c_init = ~active | start_det;  // Parks FSM and shifter

  // ==============================
  // Byte protocol FSM
  // ==============================

  always_comb begin
    state_nxt = state;
    if (i2c_init) begin
      state_nxt = RX_ADDR;
    end else begin
      case (state)
        RX_ADDR: begin
          if (shift_rx_done && !addr_miss) begin
            state_nxt = RX_ADDR_ACK;
          end
        end
        RX_ADDR_ACK: begin
          if (scl_fe) begin
            state_nxt = shift_q[0] ? TX_DATA : RX_DATA;  // R/W bit
          end
        end
        RX_DATA: begin
          if (shift_rx_done) begin
            state_nxt = RX_DATA_ACK;
          end
        end
        RX_DATA_ACK: begin
          if (scl_fe) begin
            state_nxt = RX_DATA;
          end
        end
        TX_DATA: begin
          if (shift_tx_done) begin
            state_nxt = TX_DATA_ACK;
          end
        end
        TX_DATA_ACK: begin
          if (scl_fe) begin
            state_nxt = sda ? RX_ADDR : TX_DATA;  // NACK ends the read
          end
        end
        default: state_nxt = RX_ADDR;
      endcase
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state <= RX_ADDR;
    end else begin
      state <= state_nxt;
    end
  end

  // ==============================
  // Shift register
  // ==============================

  assign shift_rx_en     = (state == RX_ADDR) | (state == RX_DATA) | (state == RX_DATA_ACK);
  assign shift_tx_en     = (state == TX_DATA) | (state == TX_DATA_ACK);
  assign shift_tx_en_pre = (state_nxt == TX_DATA) | (state_nxt == TX_DATA_ACK);

  // Marker reaches bit 8 once 8 bits are in, or once 8 bits are out
  assign shift_rx_done = shift_rx_en & scl_fe & shift_q[8];
  assign shift_tx_done = shift_tx_en & scl_fe & (shift_q == 9'h100);

  assign rx_init  = i2c_init
                  | ((state == RX_ADDR_ACK) & scl_fe & ~shift_q[0])
                  | ((state == RX_DATA_ACK) & scl_fe);
  assign tx_init  = ((state == RX_ADDR_ACK) & scl_re & shift_q[0])
                  | ((state == TX_DATA_ACK) & scl_re);
  assign rx_shift = shift_rx_en & scl_sample;
  assign tx_shift = shift_tx_en_pre & scl_fe & (shift_q != 9'h100);

  always_comb begin
    if (rx_init) begin
      shift_nxt = 9'h001;                     // Empty, marker at bit 0
    end else if (tx_init) begin
      shift_nxt = {tx_byte, 1'b1};            // Load byte for master
    end else if (rx_shift) begin
      shift_nxt = {shift_q[7:0], sda};
    end else if (tx_shift) begin
      shift_nxt = {shift_q[7:0], 1'b0};
    end else begin
      shift_nxt = shift_q;
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      shift_q <= 9'h001;
    end else begin
      shift_q <= shift_nxt;
    end
  end

  // Address byte compare, R/W bit excluded
  assign addr_miss = (state == RX_ADDR) & shift_rx_done & (shift_q[7:1] != I2C_ADDR);

  assign rx_byte.data = shift_q[7:0];
  assign rx_byte_done = shift_rx_done & (state == RX_DATA);
  assign tx_byte_done = shift_tx_done;

  // ==============================
  // SDA driver
  // ==============================

  // Changes only while SCL is low
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      sda_out <= 1'b1;
    end else if (scl_fe) begin
      sda_out <= ~((state_nxt == RX_ADDR_ACK) ||
                   (state_nxt == RX_DATA_ACK) ||
                   (tx_shift && !shift_q[8]));  // ACK or a 0 data bit
    end
  end

endmodule

/* dbg_i2c_pkg.sv */
// Shared widths, FSM encodings and command byte layout of the I2C debug front end
package dbg_i2c_pkg;

  // ==============================
  // Widths
  // ==============================

  localparam int DBG_ADDR_W = 6;   // Debug register address
  localparam int DBG_DATA_W = 16;  // Debug register word
  localparam int I2C_BYTE_W = 8;   // One byte on the bus

  // ==============================
  // State encodings
  // ==============================

  // Byte protocol FSM of the link layer
  typedef enum logic [2:0] {
    RX_ADDR     = 3'h0,  // Device address and R/W bit
    RX_ADDR_ACK = 3'h1,  // Slave ACKs the address
    RX_DATA     = 3'h2,  // Data byte from master
    RX_DATA_ACK = 3'h3,  // Slave ACKs the data byte
    TX_DATA     = 3'h4,  // Data byte to master
    TX_DATA_ACK = 3'h5   // Master ACK or NACK
  } i2c_state_e;

  // Debug command FSM
  typedef enum logic [2:0] {
    RX_CMD     = 3'h0,  // Waiting for command byte
    RX_BYTE_LO = 3'h1,
    RX_BYTE_HI = 3'h2,
    TX_BYTE_LO = 3'h3,
    TX_BYTE_HI = 3'h4
  } dbg_state_e;

  // ==============================
  // Command byte
  // ==============================

  // Same received byte, seen as plain data or as a debug command
  typedef union packed {
    logic [I2C_BYTE_W-1:0] data;      // Raw byte
    struct packed {
      logic                  wr;      // 1 = register write, 0 = read
      logic                  bw;      // 1 = 8-bit access, 0 = 16-bit
      logic [DBG_ADDR_W-1:0] addr;    // Debug register address
    } cmd;
  } dbg_cmd_u;

endpackage

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vlog.f --top-module tb_dbg_i2c -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dbg_i2c 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tb_dbg_i2c.sv */
// Directed testbench for the I2C debug front end with a bit-banged master and a register model
`timescale 1ns/1ps

module tb_dbg_i2c import dbg_i2c_pkg::*; ();

  localparam int         HALF     = 12;     // dbg_clk cycles per SCL half period
  localparam int         TIMEOUT  = 1000;   // Max cycles for any strobe wait
  localparam logic [6:0] DEV_ADDR = 7'h50;  // DUT default device address

  logic                  dbg_clk;
  logic                  dbg_rst;
  logic                  scl_m;                  // Master SCL
  logic                  sda_m;                  // Master SDA (0 pulls low)
  logic                  sda_line;               // Wired AND of both drivers
  logic                  dbg_i2c_sda_out;
  logic [DBG_ADDR_W-1:0] dbg_addr;
  logic [DBG_DATA_W-1:0] dbg_din;
  logic                  dbg_wr;
  logic                  dbg_rd;
  logic [DBG_DATA_W-1:0] dbg_dout;
  logic [DBG_DATA_W-1:0] regs [64];              // Debug register model
  int                    wr_count;
  int                    rd_count;
  logic [DBG_ADDR_W-1:0] wr_addr;                // Last write seen
  logic [DBG_DATA_W-1:0] wr_data;
  logic [DBG_ADDR_W-1:0] rd_addr;                // Last read seen
  logic [31:0]           lfsr;

  assign sda_line = sda_m & dbg_i2c_sda_out;

  dbg_i2c i_dbg_i2c (
    .dbg_clk         (dbg_clk),
    .dbg_rst         (dbg_rst),
    .dbg_i2c_scl     (scl_m),
    .dbg_i2c_sda_in  (sda_line),
    .dbg_i2c_sda_out (dbg_i2c_sda_out),
    .dbg_addr        (dbg_addr),
    .dbg_din         (dbg_din),
    .dbg_wr          (dbg_wr),
    .dbg_rd          (dbg_rd),
    .dbg_dout        (dbg_dout)
  );

  initial begin
    dbg_clk = 1'b0;
    forever #5 dbg_clk = ~dbg_clk;
  end

  // ==============================
  // Register model
  // ==============================

  // Every address bit shows up in its word
  function automatic logic [15:0] fill_word(input logic [5:0] a);
    return {a ^ 6'h2d, 2'b10, ~a, 2'b01};
  endfunction

  assign dbg_dout = regs[dbg_addr];  // Read data straight from the address

  always @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      for (int i = 0; i < 64; i++) begin
        regs[i] <= fill_word(6'(i));
      end
      wr_count <= 0;
      rd_count <= 0;
      wr_addr  <= '0;
      wr_data  <= '0;
      rd_addr  <= '0;
    end else begin
      if (dbg_wr) begin
        regs[dbg_addr] <= dbg_din;
        wr_count       <= wr_count + 1;
        wr_addr        <= dbg_addr;
        wr_data        <= dbg_din;
      end
      if (dbg_rd) begin
        rd_count <= rd_count + 1;
        rd_addr  <= dbg_addr;
      end
    end
  end

  // ==============================
  // Helpers and checks
  // ==============================

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [15:0] value);
    value = '0;
    repeat (n) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[14:0], lfsr[0]};  // One step per bit
    end
  endtask

  task automatic step_clocks(input int n);
    repeat (n) @(negedge dbg_clk);
  endtask

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected)
      else fail_stop($sformatf("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
                               test, what, expected, actual));
  endtask

  // Polls the strobe counters for at most TIMEOUT cycles
  task automatic wait_strobe(input string test, input logic is_wr, input int target);
    int n;
    n = 0;
    while (((is_wr ? wr_count : rd_count) < target) && (n < TIMEOUT)) begin
      @(negedge dbg_clk);
      n++;
    end
    assert ((is_wr ? wr_count : rd_count) >= target)
      else fail_stop($sformatf("[FAIL] %s: no %s pulse within %0d cycles",
                               test, is_wr ? "dbg_wr" : "dbg_rd", TIMEOUT));
  endtask

  // ==============================
  // I2C master
  // ==============================

  // One SCL period with SDA set mid low phase and the line sampled mid high phase
  task automatic clock_bit(input logic bit_out, output logic bit_in);
    step_clocks(HALF / 2);
    sda_m = bit_out;
    step_clocks(HALF / 2);
    scl_m = 1'b1;
    step_clocks(HALF / 2);
    bit_in = sda_line;
    step_clocks(HALF / 2);
    scl_m = 1'b0;
  endtask

  task automatic i2c_start();
    step_clocks(HALF / 2);
    sda_m = 1'b1;             // Released first for a repeated START
    step_clocks(HALF / 2);
    scl_m = 1'b1;
    step_clocks(HALF);
    sda_m = 1'b0;             // SDA falls with SCL high
    step_clocks(HALF);
    scl_m = 1'b0;
  endtask

  task automatic i2c_stop();
    step_clocks(HALF / 2);
    sda_m = 1'b0;
    step_clocks(HALF / 2);
    scl_m = 1'b1;
    step_clocks(HALF);
    sda_m = 1'b1;             // SDA rises with SCL high
    step_clocks(HALF);
  endtask

  task automatic i2c_write_byte(input logic [7:0] data, output logic ack);
    logic [7:0] shift;
    logic       dummy;
    shift = data;
    repeat (8) begin
      clock_bit(shift[7], dummy);  // MSB first
      shift = {shift[6:0], 1'b0};
    end
    clock_bit(1'b1, ack);          // Slave owns the ACK slot
  endtask

  task automatic i2c_read_byte(input logic ack, output logic [7:0] data);
    logic b;
    logic dummy;
    data = '0;
    repeat (8) begin
      clock_bit(1'b1, b);
      data = {data[6:0], b};
    end
    clock_bit(ack, dummy);         // 1 = NACK to end the read
  endtask

  // START and address with W, then one command byte that must be ACKed
  task automatic send_command(input string test, input logic wr, input logic bw,
                              input logic [5:0] addr);
    logic ack;
    i2c_start();
    i2c_write_byte({DEV_ADDR, 1'b0}, ack);
    check_value(test, "address ACK", 0, 32'(ack));
    i2c_write_byte({wr, bw, addr}, ack);   // bw = 1 for 8-bit access
    check_value(test, "command ACK", 0, 32'(ack));
  endtask

  // ==============================
  // Tests
  // ==============================

  task automatic reset_state();
    check_value("reset_state", "dbg_wr", 0, 32'(dbg_wr));
    check_value("reset_state", "dbg_rd", 0, 32'(dbg_rd));
    check_value("reset_state", "sda_out", 1, 32'(dbg_i2c_sda_out));
    check_value("reset_state", "dbg_addr", 0, 32'(dbg_addr));
    check_value("reset_state", "dbg_din", 0, 32'(dbg_din));
    step_clocks(200);                      // Idle bus
    check_value("reset_state", "dbg_wr pulses", 0, wr_count);
    check_value("reset_state", "dbg_rd pulses", 0, rd_count);
  endtask

  task automatic write_test(input string test, input logic byte_mode);
    logic [15:0] r;
    logic [5:0]  addr;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic        ack;
    int          wr_before;
    random_bits(6, r);
    addr = r[5:0];
    random_bits(8, r);
    lo = r[7:0];
    random_bits(8, r);
    hi = byte_mode ? 8'h00 : r[7:0];       // Byte write clears the high half
    wr_before = wr_count;
    send_command(test, 1'b1, byte_mode, addr);
    i2c_write_byte(lo, ack);
    check_value(test, "low byte ACK", 0, 32'(ack));
    if (!byte_mode) begin
      check_value(test, "dbg_wr pulses after low byte", wr_before, wr_count);
      i2c_write_byte(hi, ack);
      check_value(test, "high byte ACK", 0, 32'(ack));
    end
    i2c_stop();
    wait_strobe(test, 1'b1, wr_before + 1);
    check_value(test, "dbg_wr pulses", wr_before + 1, wr_count);
    check_value(test, "dbg_addr", 32'(addr), 32'(wr_addr));
    check_value(test, "dbg_din", 32'({hi, lo}), 32'(wr_data));
  endtask

  task automatic wrong_address();
    logic [15:0] r;
    logic        ack;
    int          wr_before;
    int          rd_before;
    wr_before = wr_count;
    rd_before = rd_count;
    i2c_start();
    i2c_write_byte({DEV_ADDR ^ 7'h15, 1'b0}, ack);
    check_value("wrong_address", "address ACK", 1, 32'(ack));
    random_bits(6, r);
    i2c_write_byte({2'b11, r[5:0]}, ack);  // Would be an 8-bit write command
    check_value("wrong_address", "command ACK", 1, 32'(ack));
    random_bits(8, r);
    i2c_write_byte(r[7:0], ack);
    check_value("wrong_address", "data ACK", 1, 32'(ack));
    i2c_stop();
    step_clocks(50);
    check_value("wrong_address", "dbg_wr pulses", wr_before, wr_count);
    check_value("wrong_address", "dbg_rd pulses", rd_before, rd_count);
  endtask

  task automatic read_test(input string test, input logic byte_mode);
    logic [15:0] r;
    logic [5:0]  addr;
    logic [15:0] expected;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic        ack;
    int          rd_before;
    random_bits(6, r);
    addr      = r[5:0];
    expected  = regs[addr];
    rd_before = rd_count;
    send_command(test, 1'b0, byte_mode, addr);
    wait_strobe(test, 1'b0, rd_before + 1);
    check_value(test, "dbg_rd pulses", rd_before + 1, rd_count);
    check_value(test, "dbg_rd address", 32'(addr), 32'(rd_addr));
    i2c_start();                           // Repeated START
    i2c_write_byte({DEV_ADDR, 1'b1}, ack);
    check_value(test, "read address ACK", 0, 32'(ack));
    i2c_read_byte(byte_mode, lo);          // NACK when it is the only byte
    check_value(test, "low byte", 32'(expected[7:0]), 32'(lo));
    if (!byte_mode) begin
      i2c_read_byte(1'b1, hi);
      check_value(test, "high byte", 32'(expected[15:8]), 32'(hi));
    end
    i2c_stop();
  endtask

  initial begin
    dbg_rst = 1'b1;
    scl_m   = 1'b1;            // Idle bus
    sda_m   = 1'b1;
    lfsr    = 32'ha284_29e8;
    repeat (5) @(posedge dbg_clk);
    @(negedge dbg_clk);
    dbg_rst = 1'b0;
    reset_state();
    write_test("write_16", 1'b0);
    write_test("write_8", 1'b1);
    wrong_address();
    read_test("read_16", 1'b0);
    read_test("read_8", 1'b1);
    $display("Regression passed");
    $finish;
  end

endmodule

/* vlog.f */
dbg_i2c_pkg.sv
dbg_i2c_line_filter.sv
dbg_i2c_link.sv
dbg_i2c_cmd.sv
dbg_i2c.sv
tb_dbg_i2c.sv
